// ==== dcache_subsys.f ====
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_fill_if.sv
hw/mem_dp.sv
hw/dcache.sv
hw/dcache_mshr.sv
hw/dcache_subsys.sv
dv/tb_dcache_subsys.sv

// ==== dv/tb_dcache_subsys.sv ====
// Data cache subsystem testbench: memory model, reference cache model, directed tests, timeout
`include "dcache_defs.svh"

module tb_dcache_subsys;

    import dcache_pkg::*;

    localparam int PLANNED_REQUESTS = 250;                    // 8 + 8 + 28 + 2 + 4 + 200
    localparam int CYCLE_LIMIT      = 40 * PLANNED_REQUESTS + 100;
    localparam int REQ_LIMIT        = 20;                     // Cycles one request may take
    localparam int IDX_HI           = `DCACHE_INDEX_BITS + 2;
    localparam int TAG_HI           = `DCACHE_TAG_BITS + IDX_HI;

    logic      clock;
    logic      reset;
    logic      valid;
    addr_t     addr;
    logic      is_store;
    mem_size_e size;
    data_t     st_data;
    logic      done;
    logic      hit;
    logic      ld_out;
    block_t    data_out;
    addr_t     addr_out;
    logic      mem_req;
    addr_t     mem_addr;
    logic      mem_resp;
    block_t    mem_data;

    int          seed;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          req_count;        // Cycles with mem_req high
    int          latency;
    logic [31:0] lat_rnd;
    addr_t       last_req_addr;
    logic        aborted;          // A request never completed

    block_t mem_model [addr_t];    // What the memory model holds
    block_t exp_mem   [addr_t];    // What memory should hold

    // Reference cache state
    tag_t                     ref_tag   [`DCACHE_LINES];
    block_t                   ref_block [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] ref_valid;

    dcache_subsys UUT (
        .clock   (clock),
        .reset   (reset),
        .valid   (valid),
        .addr    (addr),
        .is_store(is_store),
        .size    (size),
        .st_data (st_data),
        .done    (done),
        .hit     (hit),
        .ld_out  (ld_out),
        .data_out(data_out),
        .addr_out(addr_out),
        .mem_req (mem_req),
        .mem_addr(mem_addr),
        .mem_resp(mem_resp),
        .mem_data(mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Every block address gets its own pattern
    function automatic block_t block_init(addr_t a);
        return {a ^ 32'hc3a5_5a3c, ~a + 32'h0101_0101};
    endfunction

    function automatic block_t memory_read(addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return block_init(a);
    endfunction

    function automatic block_t expected_read(addr_t a);
        if (exp_mem.exists(a)) begin
            return exp_mem[a];
        end
        return block_init(a);
    endfunction

    // Byte by byte merge of the store lanes into a block
    function automatic block_t merge_store(block_t base, addr_t a, mem_size_e sz, data_t d);
        block_t merged;
        int     lane;
        merged = base;
        for (int i = 0; i < `BLOCK_BYTES; i++) begin
            lane = -1;
            case (sz)
                BYTE:    if (i == int'(a[2:0])) lane = 0;
                HALF:    if (i / 2 == int'(a[2:1])) lane = i % 2;
                WORD:    if (i / 4 == int'(a[2])) lane = i % 4;
                default: lane = -1;
            endcase
            if (lane >= 0) begin
                merged[8*i +: 8] = d[8*lane +: 8];
            end
        end
        return merged;
    endfunction

    task automatic compare_field(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // A strobe held for more than one cycle counts more than once
    always @(negedge clock) begin
        if (mem_req === 1'b1) begin
            req_count++;
        end
    end

    // Memory model: answers each mem_req after 1 to 6 cycles
    initial begin
        mem_resp = 1'b0;
        mem_data = '0;
        forever begin
            @(negedge clock);
            if (mem_req) begin
                last_req_addr = mem_addr;
                lat_rnd = $random(seed);
                latency = 1 + int'(lat_rnd % 6);
                repeat (latency) @(negedge clock);
                mem_data = memory_read(last_req_addr);
                mem_resp = 1'b1;
                @(negedge clock);
                mem_resp = 1'b0;
            end
        end
    end

    // One request: drive, wait for done, check against the reference, update it
    task automatic run_request(input addr_t a, input logic store, input mem_size_e sz,
                               input data_t d);
        index_t idx;
        tag_t   tg;
        addr_t  line_addr;
        logic   exp_hit;
        block_t exp_data;
        int     req_before;
        int     waited;
        if (aborted) return;
        idx       = a[IDX_HI:3];
        tg        = a[TAG_HI:IDX_HI+1];
        line_addr = {a[31:3], 3'b000};
        exp_hit   = ref_valid[idx] && (ref_tag[idx] == tg);
        exp_data  = exp_hit ? ref_block[idx] : expected_read(line_addr);
        if (store) begin
            exp_data = merge_store(exp_data, a, sz, d);
        end
        @(negedge clock);
        valid    = 1'b1;
        addr     = a;
        is_store = store;
        size     = sz;
        st_data  = d;
        req_before = req_count;
        waited     = 0;
        #1;                                    // Let the combinational outputs settle
        while (!done && waited < REQ_LIMIT) begin
            compare_field("hit", 64'(0), 64'(hit));
            @(negedge clock);
            #1;
            waited++;
        end
        if (!done) begin
            $display("Request to address %h got no done within %0d cycles", a, REQ_LIMIT);
            error_count++;
            aborted = 1'b1;
            valid   = 1'b0;
            return;
        end
        if (exp_hit) begin
            compare_field("hit latency", 64'(0), 64'(waited));    // Same cycle as the request
        end
        compare_field("hit", 64'(exp_hit), 64'(hit));
        compare_field("ld_out", 64'(!store), 64'(ld_out));
        compare_field("data_out", exp_data, data_out);
        compare_field("addr_out", 64'(line_addr), 64'(addr_out));
        compare_field("mem_req count", 64'(exp_hit ? 0 : 1), 64'(req_count - req_before));
        if (!exp_hit) begin
            compare_field("mem_addr", 64'(line_addr), 64'(last_req_addr));
        end
        if (store) begin
            mem_model[addr_out] = data_out;    // Write-through into the memory model
            exp_mem[line_addr]  = exp_data;
        end
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tg;
        ref_block[idx] = exp_data;
    endtask

    task automatic store_then_load(input addr_t a, input mem_size_e sz, input data_t d);
        run_request(a, 1'b1, sz, d);
        run_request(a, 1'b0, WORD, '0);
    endtask

    // Eight lines with tag 12, byte offsets 0 to 7 inside the block
    function automatic addr_t cold_addr(int i);
        return 32'h0000_1200 | (addr_t'(i * 3 + 1) << 3) | addr_t'(i);
    endfunction

    task automatic test_cold_misses();
        for (int i = 0; i < 8; i++) begin
            run_request(cold_addr(i), 1'b0, WORD, '0);
        end
    endtask

    task automatic test_repeat_hits();
        for (int i = 0; i < 8; i++) begin
            run_request(cold_addr(i), 1'b0, WORD, '0);
        end
    endtask

    task automatic test_store_merge();
        addr_t a;
        addr_t base;
        data_t d;
        a    = cold_addr(2);
        base = {a[31:3], 3'b000};
        for (int off = 0; off < 8; off++) begin
            d = 32'h9a7b_5c3d ^ (data_t'(off) * 32'h1111_1111);
            store_then_load(base + addr_t'(off), BYTE, d);
        end
        for (int off = 0; off < 8; off += 2) begin
            d = 32'h0000_b7e4 + data_t'(off * 257);
            store_then_load(base + addr_t'(off), HALF, d);
        end
        store_then_load(base, WORD, 32'h1357_9bdf);
        store_then_load(base + 4, WORD, 32'h2468_ace0);
    endtask

    // Line 30 is untouched so far
    task automatic test_store_miss();
        store_then_load(32'h0000_34f4, WORD, 32'h7e57_0a11);
    endtask

    // Same index 25, tags 50 and 61
    task automatic test_conflict();
        run_request(32'h0000_50c8, 1'b0, WORD, '0);
        run_request(32'h0000_61ca, 1'b0, WORD, '0);
        run_request(32'h0000_50cc, 1'b0, WORD, '0);
        run_request(32'h0000_61c8, 1'b0, WORD, '0);
    endtask

    task automatic test_random();
        logic [31:0] rnd;
        addr_t       a;
        mem_size_e   sz;
        data_t       d;
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            d   = $random(seed);
            // Half the requests use four tags so lines get reused
            a = {16'h0000, (rnd[20] ? rnd[15:8] : {6'b0, rnd[9:8]}), rnd[7:0]};
            case (rnd[23:22])
                2'd0:    sz = BYTE;
                2'd1:    sz = HALF;
                default: sz = WORD;
            endcase
            if (sz == HALF) a[0] = 1'b0;
            if (sz == WORD) a[1:0] = 2'b00;
            run_request(a, rnd[24], sz, d);
        end
    endtask

    initial begin
        seed        = 75135;
        error_count = 0;
        check_count = 0;
        req_count   = 0;
        aborted     = 1'b0;
        ref_valid   = '0;
        reset       = 1'b1;
        valid       = 1'b0;
        addr        = '0;
        is_store    = 1'b0;
        size        = WORD;
        st_data     = '0;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        test_cold_misses();
        test_repeat_hits();
        test_store_merge();
        test_store_miss();
        test_conflict();
        test_random();
        @(negedge clock);
        valid = 1'b0;
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/dcache.sv ====
// Direct mapped write-through data cache: tag array, hit detection, store merge, line write
`include "dcache_defs.svh"

module dcache (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  valid,
    input  dcache_pkg::addr_t     addr,
    input  logic                  is_store,
    input  dcache_pkg::mem_size_e size,
    input  dcache_pkg::data_t     st_data,

    dcache_fill_if.cache          fill,

    output logic                  done,
    output logic                  hit,
    output logic                  ld_out,
    output dcache_pkg::block_t    data_out,
    output dcache_pkg::addr_t     addr_out
);

    import dcache_pkg::*;

    // Highest address bit that the tag covers
    localparam int TAG_TOP = `DCACHE_TAG_BITS + `DCACHE_INDEX_BITS + 2;

    tag_t   cur_tag;
    index_t cur_index;
    block_t rd_block;      // Line data at the request index
    block_t wr_block;      // Base block with any store merged in
    logic   line_we;

    tag_t                     tag_array [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] line_valid;

    mem_dp #(
        .WIDTH(`BLOCK_BYTES * 8),
        .DEPTH(`DCACHE_LINES)
    ) data_array (
        .clock(clock),
        .reset(reset),
        .raddr(cur_index),
        .rdata(rd_block),
        .we   (line_we),
        .waddr(cur_index),
        .wdata(wr_block)
    );

    assign {cur_tag, cur_index} = addr[TAG_TOP:3];

    assign hit = line_valid[cur_index] && (tag_array[cur_index] == cur_tag);

    // Miss is held off during the fill so the handler does not restart
    assign fill.miss      = valid && !hit && !fill.fill_wr;
    assign fill.miss_addr = {addr[31:3], 3'b000};

    // Fill data wins over the stale line, then the store goes on top
    always_comb begin
        wr_block = fill.fill_wr ? fill.fill_data : rd_block;
        if (is_store) begin
            case (size)
                BYTE:    wr_block[8 * addr[2:0] +: 8]   = st_data[7:0];
                HALF:    wr_block[16 * addr[2:1] +: 16] = st_data[15:0];
                WORD:    wr_block[32 * addr[2] +: 32]   = st_data;
                default: wr_block = wr_block;    // Unused encoding leaves the block
            endcase
        end
    end

    // A fill always writes, a hit writes only for a store
    assign line_we = fill.fill_wr || (valid && hit && is_store);

    assign done     = (valid && hit) || fill.fill_wr;
    assign ld_out   = done && !is_store;
    assign data_out = wr_block;                    // Merged block on a store
    assign addr_out = {addr[31:3], 3'b000};

    // Valid bits
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (fill.fill_wr) begin
            line_valid[cur_index] <= 1'b1;
        end
    end

    // Tags are only looked at behind a set valid bit
    always_ff @(posedge clock) begin
        if (fill.fill_wr) begin
            tag_array[cur_index] <= cur_tag;
        end
    end

    // Handler only fills for a request that actually missed
    fill_without_hit: assert property (
        @(posedge clock) disable iff (reset)
        fill.fill_wr |-> !hit
    );

    // A fill must land while the requester still holds its request
    done_needs_valid: assert property (
        @(posedge clock) disable iff (reset)
        done |-> valid
    );

endmodule

// ==== hw/dcache_defs.svh ====
// Data cache geometry macros: line count, index and tag widths, block size
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Direct mapped, one block per line
`define DCACHE_LINES 32

// Index comes from address bits 7 to 3
`define DCACHE_INDEX_BITS 5

// Tag comes from address bits 15 to 8, higher bits alias
`define DCACHE_TAG_BITS 8

// One 64-bit block per line
`define BLOCK_BYTES 8

`endif

// ==== hw/dcache_fill_if.sv ====
// Miss request and line fill interface between the cache and the miss handler
interface dcache_fill_if;

    import dcache_pkg::*;

    logic   miss;        // Valid request misses, no fill this cycle
    addr_t  miss_addr;   // Block aligned request address
    logic   fill_wr;     // One cycle per fetch
    block_t fill_data;   // Fetched block, valid with fill_wr

    modport cache (
        output miss,
        output miss_addr,
        input  fill_wr,
        input  fill_data
    );

    modport mshr (
        input  miss,
        input  miss_addr,
        output fill_wr,
        output fill_data
    );

endinterface

// ==== hw/dcache_mshr.sv ====
// Single entry miss handler: memory request, response capture and line fill strobe
module dcache_mshr (
    input  logic               clock,
    input  logic               reset,

    dcache_fill_if.mshr        fill,

    output logic               mem_req,
    output dcache_pkg::addr_t  mem_addr,
    input  logic               mem_resp,
    input  dcache_pkg::block_t mem_data
);

    import dcache_pkg::*;

    mshr_state_e state;
    mshr_state_e next_state;

    addr_t  miss_addr_q;    // Held from REQUEST until the response
    block_t fill_block;     // Captured memory response

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (fill.miss) begin
                    next_state = REQUEST;
                end
            end
            REQUEST: next_state = WAIT;
            WAIT: begin
                if (mem_resp) begin
                    next_state = FILL;
                end
            end
            FILL:    next_state = IDLE;    // Back to IDLE, one fill per fetch
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Address only loads when a new fetch starts
    always_ff @(posedge clock) begin
        if (state == IDLE && fill.miss) begin
            miss_addr_q <= fill.miss_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (state == WAIT && mem_resp) begin
            fill_block <= mem_data;
        end
    end

    assign mem_req  = (state == REQUEST);
    assign mem_addr = miss_addr_q;

    assign fill.fill_wr   = (state == FILL);
    assign fill.fill_data = fill_block;

    // Memory answers only the one request in flight
    resp_only_in_wait: assert property (
        @(posedge clock) disable iff (reset)
        mem_resp |-> (state == WAIT)
    );

    // Requester must hold its address until the fill lands
    miss_addr_held: assert property (
        @(posedge clock) disable iff (reset)
        (state != IDLE) |-> $stable(fill.miss_addr)
    );

endmodule

// ==== hw/dcache_pkg.sv ====
// Data cache types: address, data, block, tag, index, access size and miss handler states
`include "dcache_defs.svh"

package dcache_pkg;

    // Byte address from the load/store unit
    typedef logic [31:0] addr_t;

    // Store data, low bits used for byte and half stores
    typedef logic [31:0] data_t;

    // Cache and memory block, byte 0 in the low bits
    typedef logic [`BLOCK_BYTES*8-1:0] block_t;

    typedef logic [`DCACHE_TAG_BITS-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

    // Store width
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    // Single entry miss handler
    typedef enum logic [1:0] {
        IDLE    = 2'h0,    // Waiting for a miss
        REQUEST = 2'h1,    // Memory request strobe
        WAIT    = 2'h2,    // Waiting for the memory response
        FILL    = 2'h3     // Line fill strobe
    } mshr_state_e;

endpackage

// ==== hw/dcache_subsys.sv ====
// Data cache subsystem top level: cache, miss handler and their fill interface
module dcache_subsys (
    input  logic                  clock,
    input  logic                  reset,

    // Requester side
    input  logic                  valid,
    input  dcache_pkg::addr_t     addr,
    input  logic                  is_store,
    input  dcache_pkg::mem_size_e size,
    input  dcache_pkg::data_t     st_data,

    output logic                  done,
    output logic                  hit,
    output logic                  ld_out,
    output dcache_pkg::block_t    data_out,
    output dcache_pkg::addr_t     addr_out,

    // Memory side
    output logic                  mem_req,
    output dcache_pkg::addr_t     mem_addr,
    input  logic                  mem_resp,
    input  dcache_pkg::block_t    mem_data
);

    dcache_fill_if fill_bus ();

    dcache u_dcache (
        .clock   (clock),
        .reset   (reset),
        .valid   (valid),
        .addr    (addr),
        .is_store(is_store),
        .size    (size),
        .st_data (st_data),
        .fill    (fill_bus.cache),
        .done    (done),
        .hit     (hit),
        .ld_out  (ld_out),
        .data_out(data_out),
        .addr_out(addr_out)
    );

    dcache_mshr u_mshr (
        .clock   (clock),
        .reset   (reset),
        .fill    (fill_bus.mshr),
        .mem_req (mem_req),
        .mem_addr(mem_addr),
        .mem_resp(mem_resp),
        .mem_data(mem_data)
    );

endmodule

// ==== hw/mem_dp.sv ====
// Block storage with asynchronous read and synchronous write
module mem_dp #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 32
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata
);

    logic [WIDTH-1:0] storage [DEPTH];

    // Read is combinational, a write shows up after the edge
    assign rdata = storage[raddr];

    always_ff @(posedge clock) begin
        if (we) begin
            storage[waddr] <= wdata;
        end
    end

    // Only matters when DEPTH is not a power of two
    waddr_in_range: assert property (
        @(posedge clock) disable iff (reset)
        we |-> (int'(waddr) < DEPTH)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the data cache subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f dcache_subsys.f \
    --top-module tb_dcache_subsys \
    -Mdir "$BUILD_DIR" \
    -o tb_dcache_subsys

"./$BUILD_DIR/tb_dcache_subsys" | tee "$LOG_FILE"

if grep -q "^RESULT: PASS$" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
